/* src.f */
+incdir+include
hdl/cpuDebugPkg.sv
hdl/masterSequencer.sv
hdl/debugController.sv
hdl/execCore.sv
hdl/memArbiter.sv
hdl/sharedMemory.sv
hdl/cpuDebugTop.sv
tests/cpuDebugAsserts.sv
tests/cpuDebugTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the cpuDebugTop testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module cpuDebugTb --Mdir obj_dir -o simv

./obj_dir/simv | tee sim.log

grep -q ">>> PASS" sim.log

/* tests/cpuDebugTb.sv */
`include "cpuDebug_defs.svh"

module cpuDebugTb
	import cpuDebugPkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT = 200;  // Cycles for any single wait

	typedef struct {
		dbgOpT       op;
		logic [7:0]  addr;
		logic [15:0] data;
		bit          hasResp;
		logic [15:0] expData;
		int          gap;        // Idle cycles first, lets the core run
	} entryT;

	logic    CLK = 1'b0;
	logic    RESET;
	logic    cmdValid;
	dbgCmdT  cmd;
	logic    cmdCredit;
	logic    respValid;
	dbgRespT resp;

	entryT       entryTable[$];
	dbgRespT     respQ[$];
	logic [15:0] prog [7];
	logic [31:0] rnd = 32'h9b90172d;
	logic [15:0] d0;
	logic [15:0] d1;
	int          sent = 0;
	int          returned = 0;
	int          respErrors = 0;
	int          creditErrors = 0;
	int          timeoutErrors = 0;

	cpuDebugTop u_dut (.CLK, .RESET, .cmdValid, .cmd, .cmdCredit, .respValid, .resp);

	always #4 CLK = ~CLK;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// Credits the host still holds
	function automatic int hostCredits();
		return `CMD_CREDITS - sent + returned;
	endfunction

	task automatic addEntry(input dbgOpT op, input logic [7:0] addr, input logic [15:0] data,
		input bit hasResp, input logic [15:0] expData, input int gap);
		entryT e;
		e = '{op, addr, data, hasResp, expData, gap};
		entryTable.push_back(e);
	endtask

	task automatic checkResp(input dbgRespT got, input dbgRespT exp, input int idx);
		if (got !== exp) begin
			respErrors++;
			$display("Fail %0t: entry %0d resp op %0d data %h, want op %0d data %h", $time, idx,
				got.op, got.data, exp.op, exp.data);
		end
	endtask

	task automatic checkCredits(input int gotBack, input int sentCmds);
		if (gotBack != sentCmds) begin
			creditErrors++;
			$display("Fail %0t: %0d credits returned for %0d commands", $time, gotBack, sentCmds);
		end
	endtask

	// Host side view, sampled away from the active edge
	always @(negedge CLK) begin
		if (!RESET) begin
			if (respValid)
				respQ.push_back(resp);
			if (cmdCredit)
				returned++;
			if (hostCredits() < 0 || hostCredits() > `CMD_CREDITS) begin
				creditErrors++;
				$display("Fail %0t: host credit count out of range", $time);
			end
		end
	end

	task automatic applyEntry(input entryT e, input int idx);
		int      t;
		dbgRespT want;
		repeat (e.gap) @(posedge CLK);
		t = 0;
		while (hostCredits() == 0 && t < TIMEOUT) begin
			@(posedge CLK);
			t++;
		end
		if (t == TIMEOUT) begin
			timeoutErrors++;
			$display("No credit came back before entry %0d", idx);
		end
		@(posedge CLK);
		#1;
		cmdValid = 1'b1;
		cmd      = '{op: e.op, addr: e.addr, data: e.data};
		sent++;
		@(posedge CLK);
		#1;
		cmdValid = 1'b0;
		if (e.hasResp) begin
			t = 0;
			while (respQ.size() == 0 && t < TIMEOUT) begin
				@(posedge CLK);
				t++;
			end
			if (respQ.size() == 0) begin
				timeoutErrors++;
				$display("No response arrived for entry %0d", idx);
			end else begin
				want = '{op: e.op, data: e.expData};
				checkResp(respQ.pop_front(), want, idx);
			end
		end
	endtask

	initial begin
		int t;
		RESET    = 1'b1;
		cmdValid = 1'b0;
		cmd      = '0;
		rnd = xorshift(rnd);
		d0  = rnd[15:0];
		rnd = xorshift(rnd);
		d1  = rnd[15:0];
		prog = '{16'h1010, 16'h2011, 16'h3012, 16'h4005, 16'h0000, 16'h3012, 16'hF000};
		// Load program and data with auto increment, then read back
		addEntry(dbgSetStop, 8'h00, 16'h0003, 0, 16'h0, 0);
		addEntry(dbgSetPtr, 8'h00, 16'h0, 0, 16'h0, 0);
		foreach (prog[i])
			addEntry(dbgWriteMem, 8'h00, prog[i], 0, 16'h0, 0);
		addEntry(dbgSetPtr, 8'h10, 16'h0, 0, 16'h0, 0);
		addEntry(dbgWriteMem, 8'h00, d0, 0, 16'h0, 0);
		addEntry(dbgWriteMem, 8'h00, d1, 0, 16'h0, 0);
		addEntry(dbgSetPtr, 8'h00, 16'h0, 0, 16'h0, 0);
		foreach (prog[i])
			addEntry(dbgReadMem, 8'h00, 16'h0, 1, prog[i], 0);
		addEntry(dbgSetPtr, 8'h10, 16'h0, 0, 16'h0, 0);
		addEntry(dbgReadMem, 8'h00, 16'h0, 1, d0, 0);
		addEntry(dbgReadMem, 8'h00, 16'h0, 1, d1, 0);
		// Steps through LDA and ADD
		addEntry(dbgStep, 8'h00, 16'h0, 1, d0, 0);
		addEntry(dbgStep, 8'h00, 16'h0, 1, 16'(d0 + d1), 0);
		// Breakpoint on the JMP at 3
		addEntry(dbgSetBkp, 8'h03, 16'h0001, 0, 16'h0, 0);
		addEntry(dbgSetStop, 8'h00, 16'h0002, 0, 16'h0, 0);
		addEntry(dbgStatus, 8'h00, 16'h0, 1, 16'h6003, 30);
		addEntry(dbgSetPtr, 8'h12, 16'h0, 0, 16'h0, 0);
		addEntry(dbgReadMem, 8'h00, 16'h0, 1, 16'(d0 + d1), 0);
		// Watch on the STA target armed before the breakpoint lets go, second store at 5
		addEntry(dbgSetWatch, 8'h12, 16'h0001, 0, 16'h0, 0);
		addEntry(dbgSetBkp, 8'h03, 16'h0000, 0, 16'h0, 0);
		addEntry(dbgSetStop, 8'h00, 16'h0002, 0, 16'h0, 0);
		addEntry(dbgStatus, 8'h00, 16'h0, 1, 16'h6006, 30);
		// Run into HALT at 6
		addEntry(dbgSetWatch, 8'h12, 16'h0000, 0, 16'h0, 0);
		addEntry(dbgSetStop, 8'h00, 16'h0002, 0, 16'h0, 0);
		addEntry(dbgStatus, 8'h00, 16'h0, 1, 16'h8006, 30);
		addEntry(dbgStatus, 8'h00, 16'h0, 1, 16'h8006, 10);

		repeat (4) @(posedge CLK);
		#1;
		RESET = 1'b0;
		foreach (entryTable[i])
			applyEntry(entryTable[i], i);

		t = 0;
		while (returned != sent && t < TIMEOUT) begin  // Drain outstanding credits
			@(posedge CLK);
			t++;
		end
		if (returned != sent) begin
			timeoutErrors++;
			$display("Credits still outstanding when the run ended");
		end
		repeat (2) @(posedge CLK);
		checkCredits(returned, sent);
		if (respQ.size() != 0) begin
			respErrors++;
			$display("Got %0d responses that no command asked for", respQ.size());
		end
		$display("Errors: resp %0d credit %0d timeout %0d", respErrors, creditErrors,
			timeoutErrors);
		if (respErrors + creditErrors + timeoutErrors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

/* tests/cpuDebugAsserts.sv */
module cpuDebugAsserts
	import cpuDebugPkg::*;
(
	input logic    CLK,
	input logic    RESET,
	input dbgCtrlT dbgCtrl,
	input seqCtrlT seqCtrl
);

	timeunit 1ns;
	timeprecision 100ps;

	// Each phase maps to exactly one of these strobes
	onePhase: assert property (@(posedge CLK) disable iff (RESET)
		$onehot({seqCtrl.stopped, seqCtrl.fetch, seqCtrl.decode, seqCtrl.execute, seqCtrl.commit}))
		else $error("more than one phase strobe, or none");

	// Request gone right after the ack, else a second step could start
	ackThenStopped: assert property (@(posedge CLK) disable iff (RESET)
		seqCtrl.debugAck |=> !seqCtrl.debugAck && seqCtrl.stopped && !dbgCtrl.debugReq)
		else $error("debugAck not a single cycle followed by stopped with debugReq low");

	// Controller keeps the step request up until the sequencer answers
	reqHeldToAck: assert property (@(posedge CLK) disable iff (RESET)
		dbgCtrl.debugReq && !seqCtrl.debugAck |=> dbgCtrl.debugReq)
		else $error("debugReq dropped before debugAck");

endmodule

bind masterSequencer cpuDebugAsserts u_asserts (.CLK(CLK), .RESET(RESET), .dbgCtrl(dbgCtrl),
	.seqCtrl(seqCtrl));

/* hdl/cpuDebugTop.sv */
`include "cpuDebug_defs.svh"

module cpuDebugTop
	import cpuDebugPkg::*;
(
	input  logic    CLK,
	input  logic    RESET,
	input  logic    cmdValid,
	input  dbgCmdT  cmd,
	output logic    cmdCredit,
	output logic    respValid,
	output dbgRespT resp
);

	seqCtrlT            seqCtrl;
	dbgCtrlT            dbgCtrl;
	logic               debugAtBkp;
	logic               debugInWatch;
	logic               haltx;
	logic [`ADDR_W-1:0] pc;
	logic [`DATA_W-1:0] acc;
	memReqT             coreMemReq;
	memReqT             dbgMemReq;
	memReqT             memReq;     // Winner, to the memory
	memRespT            coreMemResp;
	memRespT            dbgMemResp;
	logic [`DATA_W-1:0] memRdata;

	masterSequencer u_seq (
		.CLK, .RESET, .dbgCtrl, .debugAtBkp, .debugInWatch, .haltx,
		.seqCtrl, .phase()
	);

	debugController u_dbg (
		.CLK, .RESET, .cmdValid, .cmd, .seqCtrl, .pc, .acc,
		.coreWrite(coreMemReq), .memResp(dbgMemResp),
		.cmdCredit, .respValid, .resp, .dbgCtrl, .debugAtBkp, .debugInWatch,
		.memReq(dbgMemReq)
	);

	execCore u_core (
		.CLK, .RESET, .seqCtrl, .memResp(coreMemResp),
		.memReq(coreMemReq), .pc, .acc, .haltx
	);

	memArbiter u_arb (
		.CLK, .RESET, .coreReq(coreMemReq), .dbgReq(dbgMemReq), .memRdata,
		.coreResp(coreMemResp), .dbgResp(dbgMemResp), .memReq
	);

	sharedMemory u_mem (
		.CLK, .memReq, .rdata(memRdata)
	);

endmodule

/* hdl/sharedMemory.sv */
`include "cpuDebug_defs.svh"

module sharedMemory
	import cpuDebugPkg::*;
(
	input  logic               CLK,
	input  memReqT             memReq,
	output logic [`DATA_W-1:0] rdata
);

	logic [`DATA_W-1:0] mem [`MEM_DEPTH];

	// Single port: one write or one read per cycle
	always_ff @(posedge CLK) begin
		if (memReq.req) begin
			if (memReq.we)
				mem[memReq.addr] <= memReq.wdata;
			else
				rdata <= mem[memReq.addr];  // Seen one cycle after the grant
		end
	end

endmodule

/* hdl/memArbiter.sv */
`include "cpuDebug_defs.svh"

module memArbiter
	import cpuDebugPkg::*;
(
	input  logic               CLK,
	input  logic               RESET,
	input  memReqT             coreReq,
	input  memReqT             dbgReq,
	input  logic [`DATA_W-1:0] memRdata,
	output memRespT            coreResp,
	output memRespT            dbgResp,
	output memReqT             memReq
);

	logic rdPendR;      // A read was granted last cycle
	logic rdOwnerDbgR;  // ... and it belongs to the debug side

	// Core always wins, it never asks two cycles in a row
	always_comb begin
		memReq          = coreReq.req ? coreReq : dbgReq;
		coreResp        = '0;
		dbgResp         = '0;
		coreResp.gnt    = coreReq.req;
		dbgResp.gnt     = dbgReq.req & ~coreReq.req;
		coreResp.rvalid = rdPendR & ~rdOwnerDbgR;
		dbgResp.rvalid  = rdPendR & rdOwnerDbgR;
		coreResp.rdata  = memRdata;
		dbgResp.rdata   = memRdata;
	end

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			rdPendR     <= 1'b0;
			rdOwnerDbgR <= 1'b0;
		end else begin
			rdPendR     <= memReq.req & ~memReq.we;
			rdOwnerDbgR <= ~coreReq.req;
		end
	end

endmodule

/* hdl/execCore.sv */
`include "cpuDebug_defs.svh"

module execCore
	import cpuDebugPkg::*;
(
	input  logic               CLK,
	input  logic               RESET,
	input  seqCtrlT            seqCtrl,
	input  memRespT            memResp,
	output memReqT             memReq,
	output logic [`ADDR_W-1:0] pc,
	output logic [`DATA_W-1:0] acc,
	output logic               haltx
);

	logic [`DATA_W-1:0] ir;
	logic [`DATA_W-1:0] insn;        // IR, or the word arriving for it
	logic               irValidR;    // Low until the first fetch returns
	logic               fetchPendR;  // Instruction word due this cycle
	logic               opndPendR;   // Operand due this cycle
	opcodeT             opc;
	logic [`ADDR_W-1:0] opnd;
	logic               needFetch;
	logic               pcAdv;

	assign insn = (fetchPendR & memResp.rvalid) ? memResp.rdata : ir;
	assign opc  = opcodeT'(insn[`DATA_W-1 -: `OPC_W]);
	assign opnd = insn[`ADDR_W-1:0];
	// Decode with an empty IR fetches first, execute then decodes the word on the fly
	assign needFetch = seqCtrl.fetch | (seqCtrl.decode & ~irValidR & ~fetchPendR);
	assign haltx = irValidR & (ir[`DATA_W-1 -: `OPC_W] == opHalt);
	// Steps advance the PC themselves, pcEnx is off in debug
	assign pcAdv = seqCtrl.commit & (seqCtrl.pcEnx | seqCtrl.debugActive) & ~haltx;

	always_comb begin
		memReq = '0;
		if (needFetch) begin
			memReq.req  = 1'b1;
			memReq.addr = pc;
		end else if (seqCtrl.execute) begin
			memReq.addr  = opnd;
			memReq.wdata = acc;
			case (opc)
				opLda, opAdd: memReq.req = 1'b1;
				opSta: begin
					memReq.req = 1'b1;
					memReq.we  = 1'b1;
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (fetchPendR & memResp.rvalid)
			ir <= memResp.rdata;
	end

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			pc         <= '0;
			acc        <= '0;
			irValidR   <= 1'b0;
			fetchPendR <= 1'b0;
			opndPendR  <= 1'b0;
		end else begin
			fetchPendR <= needFetch & memResp.gnt;
			opndPendR  <= ~needFetch & memReq.req & ~memReq.we & memResp.gnt;
			if (fetchPendR & memResp.rvalid)
				irValidR <= 1'b1;
			if (seqCtrl.commit && irValidR) begin
				if (opndPendR & memResp.rvalid) begin
					if (opc == opLda)
						acc <= memResp.rdata;
					else if (opc == opAdd)
						acc <= acc + memResp.rdata;  // Wraps at DATA_W
				end
				if (opc == opJmp)
					pc <= opnd;
				else if (pcAdv)
					pc <= pc + 1'b1;
			end
		end
	end

endmodule

/* hdl/debugController.sv */
`include "cpuDebug_defs.svh"

module debugController
	import cpuDebugPkg::*;
(
	input  logic               CLK,
	input  logic               RESET,
	input  logic               cmdValid,
	input  dbgCmdT             cmd,
	input  seqCtrlT            seqCtrl,
	input  logic [`ADDR_W-1:0] pc,
	input  logic [`DATA_W-1:0] acc,
	input  memReqT             coreWrite,  // Core bus, snooped for the watch
	input  memRespT            memResp,
	output logic               cmdCredit,
	output logic               respValid,
	output dbgRespT            resp,
	output dbgCtrlT            dbgCtrl,
	output logic               debugAtBkp,
	output logic               debugInWatch,
	output memReqT             memReq
);

	localparam int QP_W = (`CMD_CREDITS > 1) ? $clog2(`CMD_CREDITS) : 1;
	localparam int QC_W = $clog2(`CMD_CREDITS + 1);

	dbgCmdT             cmdQ [`CMD_CREDITS];  // Credits keep it from overflowing
	dbgCmdT             headCmd;
	logic [QP_W-1:0]    wrPtrR;
	logic [QP_W-1:0]    rdPtrR;
	logic [QC_W-1:0]    countR;
	logic               qValid;
	logic               retire;               // Head command done this cycle
	logic               respNow;
	logic               stepStart;
	logic [`DATA_W-1:0] respData;
	logic               stopModeR;
	logic               incModeR;
	logic               stepBusyR;            // Drives debugReq
	logic               memWaitR;             // Read granted, data next cycle
	logic               haltedR;              // Sticky copy of the halted pulse
	logic               watchHitR;
	logic               bkpEnR;
	logic               watchEnR;
	logic [`ADDR_W-1:0] bkpAddrR;
	logic [`ADDR_W-1:0] watchAddrR;
	logic [`ADDR_W-1:0] ptrR;                 // Memory pointer

	assign headCmd   = cmdQ[rdPtrR];
	assign qValid    = countR != '0;
	assign stepStart = qValid & (headCmd.op == dbgStep) & ~stepBusyR;

	assign dbgCtrl = '{debugReq: stepBusyR, debugModeStop: stopModeR, debugModeInc: incModeR};
	// Held while parked at the breakpoint, so only a step moves past it
	assign debugAtBkp = bkpEnR & (pc == bkpAddrR) & (seqCtrl.fetch | seqCtrl.stopped);
	assign debugInWatch = watchHitR;

	always_comb begin
		memReq       = '0;
		memReq.req   = qValid & ~memWaitR & (headCmd.op inside {dbgReadMem, dbgWriteMem});
		memReq.we    = headCmd.op == dbgWriteMem;
		memReq.addr  = ptrR;
		memReq.wdata = headCmd.data;
	end

	always_comb begin
		retire   = 1'b0;
		respNow  = 1'b0;
		respData = acc;  // STEP answers with the accumulator
		if (qValid) begin
			case (headCmd.op)
				dbgStep: begin
					retire  = stepBusyR & seqCtrl.debugAck;
					respNow = retire;
				end
				dbgReadMem: begin
					retire   = memWaitR & memResp.rvalid;
					respNow  = retire;
					respData = memResp.rdata;
				end
				dbgWriteMem: retire = memResp.gnt;  // Write lands at the grant edge
				dbgStatus: begin
					retire   = 1'b1;
					respNow  = 1'b1;
					respData = {haltedR, seqCtrl.debugActive, seqCtrl.stopped,
						{(`DATA_W - 3 - `ADDR_W){1'b0}}, pc};
				end
				default: retire = 1'b1;  // Register writes take one cycle
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (cmdValid)
			cmdQ[wrPtrR] <= cmd;
		resp <= '{op: headCmd.op, data: respData};
	end

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			wrPtrR     <= '0;
			rdPtrR     <= '0;
			countR     <= '0;
			cmdCredit  <= 1'b0;
			respValid  <= 1'b0;
			stopModeR  <= 1'b1;  // Core comes up stopped
			incModeR   <= 1'b0;
			stepBusyR  <= 1'b0;
			memWaitR   <= 1'b0;
			haltedR    <= 1'b0;
			watchHitR  <= 1'b0;
			bkpEnR     <= 1'b0;
			watchEnR   <= 1'b0;
			bkpAddrR   <= '0;
			watchAddrR <= '0;
			ptrR       <= '0;
		end else begin
			if (cmdValid)
				wrPtrR <= (wrPtrR == QP_W'(`CMD_CREDITS - 1)) ? '0 : wrPtrR + 1'b1;
			if (retire)
				rdPtrR <= (rdPtrR == QP_W'(`CMD_CREDITS - 1)) ? '0 : rdPtrR + 1'b1;
			countR    <= countR + QC_W'(cmdValid) - QC_W'(retire);
			cmdCredit <= retire;   // Same cycle as the response
			respValid <= respNow;
			if (stepStart)
				stepBusyR <= 1'b1;
			else if (retire && headCmd.op == dbgStep)
				stepBusyR <= 1'b0;  // Dropped right after debugAck
			if (memReq.req & ~memReq.we & memResp.gnt)
				memWaitR <= 1'b1;
			else if (memResp.rvalid)
				memWaitR <= 1'b0;
			if (stepStart)
				haltedR <= 1'b0;
			else if (seqCtrl.halted)
				haltedR <= 1'b1;
			// Watch hit lives until the next step or a new watch setting
			if (stepStart || (retire && headCmd.op == dbgSetWatch))
				watchHitR <= 1'b0;
			if (watchEnR && coreWrite.req && coreWrite.we && coreWrite.addr == watchAddrR)
				watchHitR <= 1'b1;
			if (retire) begin
				case (headCmd.op)
					dbgSetStop: begin
						stopModeR <= headCmd.data[0];
						incModeR  <= headCmd.data[1];
					end
					dbgSetBkp: begin
						bkpAddrR <= headCmd.addr;
						bkpEnR   <= headCmd.data[0];
					end
					dbgSetWatch: begin
						watchAddrR <= headCmd.addr;
						watchEnR   <= headCmd.data[0];
					end
					default: ;
				endcase
			end
			// Pointer load wins over both kinds of auto increment
			if (retire && headCmd.op == dbgSetPtr)
				ptrR <= headCmd.addr;
			else if (retire && incModeR && (headCmd.op inside {dbgReadMem, dbgWriteMem}))
				ptrR <= ptrR + 1'b1;
			else if (seqCtrl.debugMrAddrIncx)
				ptrR <= ptrR + 1'b1;
		end
	end

endmodule

/* hdl/masterSequencer.sv */
module masterSequencer
	import cpuDebugPkg::*;
(
	input  logic    CLK,
	input  logic    RESET,
	input  dbgCtrlT dbgCtrl,
	input  logic    debugAtBkp,
	input  logic    debugInWatch,
	input  logic    haltx,
	output seqCtrlT seqCtrl,
	output phaseT   phase
);

	// Phases run one cycle each; stop conditions only count at a fetch boundary
	phaseT phaseNext;
	logic  resetR;           // First cycle out of reset
	logic  reqArmedR;        // Cleared by a step, rearmed once debugReq drops
	logic  stopCond;
	logic  debugActiveNext;

	assign stopCond = dbgCtrl.debugModeStop | debugAtBkp | debugInWatch;

	assign debugActiveNext = phaseNext inside {phDebugStopped, phDebugDecode, phDebugExecute,
		phDebugCommit, phDebugFetch, phDebugAck};

	always_comb begin
		case (phase)
			phStopped: begin
				if (stopCond)
					phaseNext = phDebugStopped;
				else if (resetR | haltx)
					phaseNext = phFetch;   // Nothing fetched yet, or refetch the HALT
				else
					phaseNext = phDecode;  // Resume on the instruction already in the IR
			end
			phFetch:        phaseNext = stopCond ? phDebugStopped : phDecode;
			phDecode:       phaseNext = phExecute;
			phExecute:      phaseNext = phCommit;
			phCommit:       phaseNext = phFetch;
			phDebugStopped: begin
				if (dbgCtrl.debugReq & reqArmedR)
					phaseNext = phDebugDecode;  // One step
				else if (!stopCond)
					phaseNext = phStopped;      // Released
				else
					phaseNext = phDebugStopped;
			end
			phDebugDecode:  phaseNext = phDebugExecute;
			phDebugExecute: phaseNext = phDebugCommit;
			phDebugCommit:  phaseNext = phDebugFetch;
			phDebugFetch:   phaseNext = phDebugAck;
			phDebugAck:     phaseNext = phDebugStopped;
			default:        phaseNext = phStopped;
		endcase
	end

	// A held debugReq must not start a second step
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			reqArmedR <= 1'b1;
		end else if (phaseNext == phDebugDecode) begin
			reqArmedR <= 1'b0;
		end else if (phaseNext == phDebugStopped && !dbgCtrl.debugReq) begin
			reqArmedR <= 1'b1;
		end
	end

	// Strobes are decoded from the next phase so they line up with it
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			phase           <= phStopped;
			resetR          <= 1'b1;
			seqCtrl         <= '0;
			seqCtrl.stopped <= 1'b1;  // Stop mode resets set, so pcEnx starts low
		end else begin
			phase                   <= phaseNext;
			resetR                  <= 1'b0;
			seqCtrl.stopped         <= phaseNext inside {phStopped, phDebugStopped, phDebugAck};
			seqCtrl.fetch           <= phaseNext inside {phFetch, phDebugFetch};
			seqCtrl.decode          <= phaseNext inside {phDecode, phDebugDecode};
			seqCtrl.execute         <= phaseNext inside {phExecute, phDebugExecute};
			seqCtrl.commit          <= phaseNext inside {phCommit, phDebugCommit};
			seqCtrl.debugAck        <= phaseNext == phDebugAck;
			seqCtrl.debugMrAddrIncx <= (phaseNext == phDebugAck) & dbgCtrl.debugModeInc;
			seqCtrl.halted <= (phaseNext inside {phDecode, phDebugDecode}) & haltx;
			seqCtrl.debugActive     <= debugActiveNext;
			// Free-running PC enable, held low in debug and on HALT
			if (resetR)
				seqCtrl.pcEnx <= ~dbgCtrl.debugModeStop & ~haltx;
			else
				seqCtrl.pcEnx <= ~debugActiveNext & ~haltx;
		end
	end

endmodule

/* hdl/cpuDebugPkg.sv */
`include "cpuDebug_defs.svh"

package cpuDebugPkg;

	typedef enum logic [3:0] {
		phStopped      = 4'd0,
		phFetch        = 4'd1,
		phDecode       = 4'd2,
		phExecute      = 4'd3,
		phCommit       = 4'd4,
		phDebugStopped = 4'd5,
		phDebugDecode  = 4'd6,
		phDebugExecute = 4'd7,
		phDebugCommit  = 4'd8,
		phDebugFetch   = 4'd9,
		phDebugAck     = 4'd10
	} phaseT;

	// Instruction word is {opcode, unused, 8-bit operand address}
	typedef enum logic [`OPC_W-1:0] {
		opNop  = 4'h0,
		opLda  = 4'h1,  // acc = mem[a]
		opAdd  = 4'h2,  // acc = acc + mem[a]
		opSta  = 4'h3,  // mem[a] = acc
		opJmp  = 4'h4,  // pc = a
		opHalt = 4'hF
	} opcodeT;

	typedef enum logic [2:0] {
		dbgSetStop  = 3'd0,  // data[0] stop mode, data[1] increment mode
		dbgSetBkp   = 3'd1,  // addr is the breakpoint, data[0] enables it
		dbgSetWatch = 3'd2,  // addr is the watch address, data[0] enables it
		dbgStep     = 3'd3,
		dbgSetPtr   = 3'd4,
		dbgReadMem  = 3'd5,
		dbgWriteMem = 3'd6,
		dbgStatus   = 3'd7
	} dbgOpT;

	typedef struct packed {
		dbgOpT              op;
		logic [`ADDR_W-1:0] addr;
		logic [`DATA_W-1:0] data;
	} dbgCmdT;

	typedef struct packed {
		dbgOpT              op;  // Echo of the command
		logic [`DATA_W-1:0] data;
	} dbgRespT;

	typedef struct packed {
		logic               req;
		logic               we;
		logic [`ADDR_W-1:0] addr;
		logic [`DATA_W-1:0] wdata;
	} memReqT;

	typedef struct packed {
		logic               gnt;     // Same cycle as req
		logic               rvalid;  // One cycle after a read grant
		logic [`DATA_W-1:0] rdata;
	} memRespT;

	typedef struct packed {
		logic stopped;
		logic fetch;
		logic decode;
		logic execute;
		logic commit;
		logic debugAck;
		logic debugMrAddrIncx;
		logic halted;
		logic pcEnx;
		logic debugActive;
	} seqCtrlT;

	typedef struct packed {
		logic debugReq;
		logic debugModeStop;
		logic debugModeInc;
	} dbgCtrlT;

endpackage

/* include/cpuDebug_defs.svh */
`ifndef CPU_DEBUG_DEFS_SVH
`define CPU_DEBUG_DEFS_SVH

// Datapath sizing
`define DATA_W      16      // Memory word and accumulator
`define ADDR_W      8       // Word address, also the PC width
`define MEM_DEPTH   256     // Words in the shared memory

// Opcode field sits in the top nibble of an instruction word
`define OPC_W       4

// Host command channel
// Slots in the command queue, the host starts with this many credits
`define CMD_CREDITS 2

`endif
